// ==== include/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

`define N_CORE      4
`define PIX_W       8
`define WGT_W       8
`define ACC_W       24
`define FEA_W       4   // Map edge up to 8
`define ADDR_W      6
`define CORE_IDX_W  2

`endif

// ==== list.f ====
+incdir+include
src/conv_pkg.sv
src/conv_ctrl.sv
src/conv_weight_loader.sv
src/conv_core.sv
src/conv_out_collector.sv
src/conv_top.sv
test/conv_sva.sv
test/conv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the conv_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f list.f --top-module conv_tb > build.log 2>&1 \
  && ./obj_dir/Vconv_tb > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== src/conv_core.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_core #(
  parameter int CORE_ID = 0
) (
  input  logic               clk,
  input  logic               xrst,
  input  logic               wgt_we,
  input  logic [`WGT_W-1:0]  wgt_data,
  input  logic [`PIX_W-1:0]  pix_d,
  input  logic               feat_we,
  input  logic               feat_clr,
  input  logic [`ADDR_W-1:0] feat_raddr,
  input  logic [`ADDR_W-1:0] feat_waddr,
  output logic [`ACC_W-1:0]  acc_out
);

  logic signed [`WGT_W-1:0] wgt_q;
  logic signed [`ACC_W-1:0] pix_ext;
  logic signed [`ACC_W-1:0] wgt_ext;
  logic signed [`ACC_W-1:0] prod;
  logic signed [`ACC_W-1:0] rd_q;
  logic signed [`ACC_W-1:0] wr_val;
  logic        [`ACC_W-1:0] mem [0:(1<<`ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wgt_q <= '0;
    end else if (wgt_we) begin
      wgt_q <= wgt_data;
    end
  end

  assign pix_ext = {{(`ACC_W-`PIX_W){1'b0}}, pix_d};            // Pixels are unsigned
  assign wgt_ext = {{(`ACC_W-`WGT_W){wgt_q[`WGT_W-1]}}, wgt_q};
  assign wr_val  = feat_clr ? prod : rd_q + prod;

  always_ff @(posedge clk) begin
    prod <= pix_ext * wgt_ext;
    if (feat_we) mem[feat_waddr] <= wr_val;
    // Forward a write that hits the address being read
    if (feat_we && feat_waddr == feat_raddr) begin
      rd_q <= wr_val;
    end else begin
      rd_q <= mem[feat_raddr];
    end
  end

  assign acc_out = rd_q;

endmodule

// ==== src/conv_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_ctrl (
  input  logic                  clk,
  input  logic                  xrst,
  input  conv_pkg::core_state_t core_state,
  input  logic [`FEA_W-1:0]     fea_size,
  input  logic                  in_start,
  input  logic                  in_valid,
  input  logic                  first_input,
  input  logic                  last_input,
  input  logic [`PIX_W-1:0]     in_pixel,
  input  logic                  busy,
  output logic                  feat_we,
  output logic                  feat_clr,
  output logic [`ADDR_W-1:0]    feat_raddr,
  output logic [`ADDR_W-1:0]    feat_waddr,
  output logic [`PIX_W-1:0]     pix_d,
  output logic                  grp_valid,
  output logic                  grp_last
);
  import conv_pkg::*;

  ctrl_state_t        state;
  logic [`FEA_W-1:0]  fea_q;
  logic [`FEA_W-1:0]  fea_max;
  logic [`FEA_W-1:0]  pos_x;
  logic [`FEA_W-1:0]  pos_y;
  logic [`ADDR_W-1:0] pos_addr;
  logic               sums_ready;
  logic               at_last;
  logic               accept;
  logic               issue;
  logic               step;
  logic               we_d0;
  logic               clr_d0;
  logic               rd_d0;
  logic               last_d0;

  assign fea_max = fea_q - 1'b1;
  assign at_last = (pos_x == fea_max) && (pos_y == fea_max);
  assign accept  = (state == S_ACTIVE) && (core_state == CORE_INPUT) && in_valid;
  // One group in flight at a time
  assign issue   = (state == S_ACTIVE) && (core_state == CORE_OUTPUT) && sums_ready
                   && !busy && !rd_d0 && !grp_valid;
  assign step    = accept || issue;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
      fea_q <= '0;
    end else begin
      case (state)
        S_WAIT: if (in_start) begin
          state <= S_ACTIVE;
          fea_q <= fea_size;
        end
        S_ACTIVE: if (issue && at_last) state <= S_WAIT;  // Final group issued
      endcase
    end
  end

  // Raster position with the linear address following x and y
  always_ff @(posedge clk) begin
    if (!xrst) begin
      pos_x    <= '0;
      pos_y    <= '0;
      pos_addr <= '0;
    end else if (state == S_WAIT) begin
      pos_x    <= '0;
      pos_y    <= '0;
      pos_addr <= '0;
    end else if (step) begin
      if (pos_x == fea_max) begin
        pos_x <= '0;
        if (pos_y == fea_max) begin
          pos_y    <= '0;
          pos_addr <= '0;
        end else begin
          pos_y    <= pos_y + 1'b1;
          pos_addr <= pos_addr + 1'b1;
        end
      end else begin
        pos_x    <= pos_x + 1'b1;
        pos_addr <= pos_addr + 1'b1;
      end
    end
  end

  // Set once the last channel has been fully accumulated
  always_ff @(posedge clk) begin
    if (!xrst) begin
      sums_ready <= 1'b0;
    end else if (state == S_WAIT) begin
      sums_ready <= 1'b0;
    end else if (accept && at_last && last_input) begin
      sums_ready <= 1'b1;
    end else if (issue && at_last) begin
      sums_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we_d0      <= 1'b0;
      clr_d0     <= 1'b0;
      feat_we    <= 1'b0;
      feat_clr   <= 1'b0;
      rd_d0      <= 1'b0;
      last_d0    <= 1'b0;
      grp_valid  <= 1'b0;
      grp_last   <= 1'b0;
      feat_raddr <= '0;
      feat_waddr <= '0;
    end else begin
      we_d0     <= accept;                 // Read slot
      clr_d0    <= accept && first_input;
      feat_we   <= we_d0;                  // Write slot
      feat_clr  <= clr_d0;
      rd_d0     <= issue;
      last_d0   <= issue && at_last;
      grp_valid <= rd_d0;                  // Lines up with acc_out
      grp_last  <= last_d0;
      if (step) feat_raddr <= pos_addr;
      feat_waddr <= feat_raddr;
    end
  end

  always_ff @(posedge clk) begin
    pix_d <= in_pixel;
  end

endmodule

// ==== src/conv_out_collector.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_out_collector (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      grp_valid,
  input  logic                      grp_last,
  input  logic [`N_CORE*`ACC_W-1:0] acc_all,
  output logic                      busy,
  output logic                      done,
  output logic                      out_req,
  input  logic                      out_ack,
  output logic [`ACC_W-1:0]         out_data,
  output logic [`CORE_IDX_W-1:0]    out_ch
);
  import conv_pkg::*;

  xfer_state_t               state;
  logic [`N_CORE*`ACC_W-1:0] grp_q;
  logic [`CORE_IDX_W-1:0]    idx;
  logic                      last_q;

  always_ff @(posedge clk) begin
    if (grp_valid && !busy) grp_q <= acc_all;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= X_IDLE;
      busy    <= 1'b0;
      done    <= 1'b0;
      out_req <= 1'b0;
      idx     <= '0;
      last_q  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (grp_valid) begin
          busy   <= 1'b1;
          last_q <= grp_last;
          idx    <= '0;
          state  <= X_IDLE;
        end
      end else begin
        case (state)
          X_IDLE: if (!out_ack) begin  // Previous ack fully released
            out_req <= 1'b1;
            state   <= X_REQ;
          end
          X_REQ: if (out_ack) begin
            out_req <= 1'b0;
            state   <= X_RELEASE;
          end
          X_RELEASE: if (!out_ack) begin
            state <= X_IDLE;
            if (idx == `CORE_IDX_W'(`N_CORE-1)) begin
              busy <= 1'b0;
              done <= last_q;
            end else begin
              idx <= idx + 1'b1;
            end
          end
          default: state <= X_IDLE;
        endcase
      end
    end
  end

  // Data moves only while req and ack are both low
  always_ff @(posedge clk) begin
    if (busy && state == X_IDLE && !out_ack) begin
      out_data <= grp_q[idx*`ACC_W +: `ACC_W];
      out_ch   <= idx;
    end
  end

endmodule

// ==== src/conv_pkg.sv ====
package conv_pkg;

  // Layer phase from the external sequencer
  typedef enum logic [1:0] {
    CORE_WAIT    = 2'd0,
    CORE_NETWORK = 2'd1,
    CORE_INPUT   = 2'd2,
    CORE_OUTPUT  = 2'd3
  } core_state_t;

  typedef enum logic {
    S_WAIT   = 1'b0,
    S_ACTIVE = 1'b1
  } ctrl_state_t;

  // Four-phase handshake progress
  typedef enum logic [1:0] {
    X_IDLE    = 2'd0,
    X_REQ     = 2'd1,
    X_RELEASE = 2'd2
  } xfer_state_t;

endpackage

// ==== src/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_top (
  input  logic                   clk,
  input  logic                   xrst,
  input  conv_pkg::core_state_t  core_state,
  input  logic [`FEA_W-1:0]      fea_size,
  input  logic                   in_start,
  input  logic                   in_valid,
  input  logic [`PIX_W-1:0]      in_pixel,
  input  logic                   first_input,
  input  logic                   last_input,
  input  logic                   w_req,
  input  logic [`WGT_W-1:0]      w_data,
  output logic                   w_ack,
  output logic                   out_req,
  output logic [`ACC_W-1:0]      out_data,
  output logic [`CORE_IDX_W-1:0] out_ch,
  input  logic                   out_ack,
  output logic                   done
);

  logic                      feat_we;
  logic                      feat_clr;
  logic [`ADDR_W-1:0]        feat_raddr;
  logic [`ADDR_W-1:0]        feat_waddr;
  logic [`PIX_W-1:0]         pix_d;
  logic                      grp_valid;
  logic                      grp_last;
  logic                      busy;
  logic [`N_CORE-1:0]        wgt_we;
  logic [`WGT_W-1:0]         wgt_data;
  logic [`N_CORE*`ACC_W-1:0] acc_all;

  conv_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .core_state  (core_state),
    .fea_size    (fea_size),
    .in_start    (in_start),
    .in_valid    (in_valid),
    .first_input (first_input),
    .last_input  (last_input),
    .in_pixel    (in_pixel),
    .busy        (busy),
    .feat_we     (feat_we),
    .feat_clr    (feat_clr),
    .feat_raddr  (feat_raddr),
    .feat_waddr  (feat_waddr),
    .pix_d       (pix_d),
    .grp_valid   (grp_valid),
    .grp_last    (grp_last)
  );

  conv_weight_loader u_loader (
    .clk        (clk),
    .xrst       (xrst),
    .core_state (core_state),
    .w_req      (w_req),
    .w_data     (w_data),
    .w_ack      (w_ack),
    .wgt_we     (wgt_we),
    .wgt_data   (wgt_data)
  );

  for (genvar i = 0; i < `N_CORE; i++) begin : g_core
    conv_core #(
      .CORE_ID (i)
    ) u_core (
      .clk        (clk),
      .xrst       (xrst),
      .wgt_we     (wgt_we[i]),
      .wgt_data   (wgt_data),
      .pix_d      (pix_d),
      .feat_we    (feat_we),
      .feat_clr   (feat_clr),
      .feat_raddr (feat_raddr),
      .feat_waddr (feat_waddr),
      .acc_out    (acc_all[i*`ACC_W +: `ACC_W])
    );
  end

  conv_out_collector u_collector (
    .clk       (clk),
    .xrst      (xrst),
    .grp_valid (grp_valid),
    .grp_last  (grp_last),
    .acc_all   (acc_all),
    .busy      (busy),
    .done      (done),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_data  (out_data),
    .out_ch    (out_ch)
  );

endmodule

// ==== src/conv_weight_loader.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_weight_loader (
  input  logic                  clk,
  input  logic                  xrst,
  input  conv_pkg::core_state_t core_state,
  input  logic                  w_req,
  input  logic [`WGT_W-1:0]     w_data,
  output logic                  w_ack,
  output logic [`N_CORE-1:0]    wgt_we,
  output logic [`WGT_W-1:0]     wgt_data
);
  import conv_pkg::*;

  xfer_state_t            state;
  logic [`CORE_IDX_W-1:0] idx;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state  <= X_IDLE;
      idx    <= '0;
      w_ack  <= 1'b0;
      wgt_we <= '0;
    end else begin
      wgt_we <= '0;
      case (state)
        X_IDLE: if (w_req && core_state == CORE_NETWORK) begin
          w_ack  <= 1'b1;
          wgt_we <= `N_CORE'(1) << idx;  // One-hot core select
          idx    <= (idx == `CORE_IDX_W'(`N_CORE-1)) ? '0 : idx + 1'b1;
          state  <= X_REQ;
        end
        X_REQ: if (!w_req) begin
          w_ack <= 1'b0;
          state <= X_RELEASE;
        end
        X_RELEASE: state <= X_IDLE;
        default:   state <= X_IDLE;
      endcase
      if (core_state != CORE_NETWORK) idx <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == X_IDLE && w_req) wgt_data <= w_data;
  end

endmodule

// ==== test/conv_golden.txt ====
# run count, then per run: fea_size channels / one weight per core / pixels, one line per channel
# then expected sums, one line per position in core order, signed decimal
3
2 2
3 -2 5 1
10 20 30 40
1 2 3 4
33 -22 55 11
66 -44 110 22
99 -66 165 33
132 -88 220 44
3 1
-1 7 0 127
5 9 13 100 200 255 0 17 64
-5 35 0 635
-9 63 0 1143
-13 91 0 1651
-100 700 0 12700
-200 1400 0 25400
-255 1785 0 32385
0 0 0 0
-17 119 0 2159
-64 448 0 8128
2 3
-128 2 -3 64
255 128 7 0
255 1 50 9
255 3 100 11
-97920 1530 -2295 48960
-16896 264 -396 8448
-20096 314 -471 10048
-2560 40 -60 1280

// ==== test/conv_sva.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_sva (
  input logic                   clk,
  input logic                   xrst,
  input conv_pkg::core_state_t  core_state,
  input logic                   w_req,
  input logic                   w_ack,
  input logic                   out_req,
  input logic                   out_ack,
  input logic [`ACC_W-1:0]      out_data,
  input logic [`CORE_IDX_W-1:0] out_ch,
  input logic                   done,
  input logic                   busy,
  input logic                   grp_valid,
  input logic                   feat_we,
  input logic                   feat_clr,
  input logic [`N_CORE-1:0]     wgt_we
);
  import conv_pkg::*;

  out_hold: assert property (@(posedge clk) disable iff (!xrst)
    (out_req && !out_ack) |=> (out_req && $stable(out_data) && $stable(out_ch)))
    else $error("out_req or its data changed before out_ack");

  w_ack_rise: assert property (@(posedge clk) disable iff (!xrst)
    $rose(w_ack) |-> $past(w_req))
    else $error("w_ack rose without w_req");

  w_ack_fall: assert property (@(posedge clk) disable iff (!xrst)
    $fell(w_ack) |-> !$past(w_req))
    else $error("w_ack fell while w_req was still high");

  no_out_in_input: assert property (@(posedge clk) disable iff (!xrst)
    (core_state == CORE_INPUT) |-> !out_req)
    else $error("out_req raised during the input phase");

  // Control outputs come out of reset low
  reset_state: assert property (@(posedge clk)
    !xrst |=> (!w_ack && !out_req && !done && !busy && !grp_valid
               && wgt_we == '0 && !feat_we && !feat_clr))
    else $error("control output not low after reset");

endmodule

bind conv_top conv_sva i_sva (
  .clk        (clk),
  .xrst       (xrst),
  .core_state (core_state),
  .w_req      (w_req),
  .w_ack      (w_ack),
  .out_req    (out_req),
  .out_ack    (out_ack),
  .out_data   (out_data),
  .out_ch     (out_ch),
  .done       (done),
  .busy       (busy),
  .grp_valid  (grp_valid),
  .feat_we    (feat_we),
  .feat_clr   (feat_clr),
  .wgt_we     (wgt_we)
);

// ==== test/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_tb;
  import conv_pkg::*;

  logic                   clk = 1'b0;
  logic                   xrst;
  core_state_t            core_state;
  logic [`FEA_W-1:0]      fea_size;
  logic                   in_start;
  logic                   in_valid;
  logic [`PIX_W-1:0]      in_pixel;
  logic                   first_input;
  logic                   last_input;
  logic                   w_req;
  logic [`WGT_W-1:0]      w_data;
  logic                   w_ack;
  logic                   out_req;
  logic [`ACC_W-1:0]      out_data;
  logic [`CORE_IDX_W-1:0] out_ch;
  logic                   out_ack;
  logic                   done;

  int run_fea[$];
  int run_nch[$];
  int wgt_list[$];
  int pix_list[$];
  int exp_list[$];
  int done_cnt = 0;
  int limit_cycles = 0;

  conv_top i_dut (
    .clk         (clk),
    .xrst        (xrst),
    .core_state  (core_state),
    .fea_size    (fea_size),
    .in_start    (in_start),
    .in_valid    (in_valid),
    .in_pixel    (in_pixel),
    .first_input (first_input),
    .last_input  (last_input),
    .w_req       (w_req),
    .w_data      (w_data),
    .w_ack       (w_ack),
    .out_req     (out_req),
    .out_data    (out_data),
    .out_ch      (out_ch),
    .out_ack     (out_ack),
    .done        (done)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic read_value(input int fd, output int v);
    if ($fscanf(fd, "%d", v) != 1) abort_run("The golden file ended early or holds a bad value");
  endtask

  // Requester side of the weight handshake
  task automatic send_weight(input int w);
    w_req  <= 1'b1;
    w_data <= `WGT_W'(w);
    @(posedge clk);
    while (!w_ack) @(posedge clk);
    w_req <= 1'b0;
    @(posedge clk);
    while (w_ack) @(posedge clk);
  endtask

  task automatic take_output(input int expected, input int core);
    int gap;
    @(posedge clk);
    while (!out_req) @(posedge clk);
    check("out_data", 32'(out_data), 32'(expected[`ACC_W-1:0]));
    check("out_ch", 32'(out_ch), core);
    gap = $urandom % 4;  // Slow consumer
    repeat (gap) @(posedge clk);
    out_ack <= 1'b1;
    @(posedge clk);
    while (out_req) @(posedge clk);
    out_ack <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (xrst && done) done_cnt <= done_cnt + 1;
    if (xrst && core_state != CORE_OUTPUT) check("out_req", 32'(out_req), 32'd0);
  end

  initial begin
    int fd;
    int n_runs;
    int v;
    int fea;
    int nch;
    int r;
    int c;
    int p;
    int k;
    int ptr_w;
    int ptr_p;
    int ptr_e;
    logic [8*120-1:0] line;
    xrst        = 1'b0;
    core_state  = CORE_WAIT;
    fea_size    = '0;
    in_start    = 1'b0;
    in_valid    = 1'b0;
    in_pixel    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    w_req       = 1'b0;
    w_data      = '0;
    out_ack     = 1'b0;
    void'($urandom(32'h1a89));

    fd = $fopen("test/conv_golden.txt", "r");
    if (fd == 0) abort_run("Could not open test/conv_golden.txt");
    void'($fgets(line, fd));  // Two header lines
    void'($fgets(line, fd));
    read_value(fd, n_runs);
    for (r = 0; r < n_runs; r++) begin
      read_value(fd, fea);
      read_value(fd, nch);
      run_fea.push_back(fea);
      run_nch.push_back(nch);
      for (k = 0; k < `N_CORE; k++) begin
        read_value(fd, v);
        wgt_list.push_back(v);
      end
      for (p = 0; p < nch * fea * fea; p++) begin
        read_value(fd, v);
        pix_list.push_back(v);
      end
      for (p = 0; p < fea * fea * `N_CORE; p++) begin
        read_value(fd, v);
        exp_list.push_back(v);
      end
    end
    $fclose(fd);
    limit_cycles = (pix_list.size() + exp_list.size() + wgt_list.size() + 20 * n_runs) * 20;

    repeat (10) @(posedge clk);
    xrst <= 1'b1;
    repeat (2) @(posedge clk);
    ptr_w = 0;
    ptr_p = 0;
    ptr_e = 0;
    for (r = 0; r < n_runs; r++) begin
      fea = run_fea[r];
      nch = run_nch[r];
      core_state <= CORE_NETWORK;
      @(posedge clk);
      for (k = 0; k < `N_CORE; k++) begin
        send_weight(wgt_list[ptr_w]);
        ptr_w++;
      end
      core_state <= CORE_WAIT;
      fea_size   <= `FEA_W'(fea);
      in_start   <= 1'b1;
      @(posedge clk);
      in_start   <= 1'b0;
      core_state <= CORE_INPUT;
      // Channels back to back and the first one overwrites old sums
      for (c = 0; c < nch; c++) begin
        for (p = 0; p < fea * fea; p++) begin
          @(posedge clk);
          in_valid    <= 1'b1;
          in_pixel    <= `PIX_W'(pix_list[ptr_p]);
          first_input <= (c == 0);
          last_input  <= (c == nch - 1);
          ptr_p++;
        end
      end
      @(posedge clk);
      in_valid    <= 1'b0;
      first_input <= 1'b0;
      last_input  <= 1'b0;
      repeat (2) @(posedge clk);
      core_state <= CORE_OUTPUT;
      for (p = 0; p < fea * fea; p++) begin
        for (k = 0; k < `N_CORE; k++) begin
          take_output(exp_list[ptr_e], k);
          ptr_e++;
        end
      end
      check("done_count", done_cnt, r);  // No early done
      while (done_cnt != r + 1) @(posedge clk);
      core_state <= CORE_WAIT;
      repeat (3) @(posedge clk);
    end
    check("done_count", done_cnt, n_runs);
    $display("STATUS: PASS");
    $finish;
  end

  // Watchdog sized from the golden file contents
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    abort_run("Timeout: the DUT stopped responding before all outputs arrived");
  end

endmodule
